// ==== iir_dsp_pkg.sv ====
/*
 * IIR DSP definitions
 * Sample, coefficient and accumulator widths plus the
 * coefficient set and tagged sample types
 */

package iir_dsp_pkg;

  // ------------------------------------------------------------
  // Datapath widths
  // ------------------------------------------------------------

  // Signed audio sample
  localparam int SAMPLE_W = 16;

  // Signed Q2.14 coefficient
  localparam int COEF_W = 16;
  localparam int COEF_FRAC = 14;

  // Five 32 bit products summed with headroom
  localparam int ACC_W = 36;

  // Channel tag carried beside each sample
  localparam int CH_W = 8;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------

  // Direct form I coefficient set shared by all channels
  typedef struct packed {
    logic signed [COEF_W-1:0] b0;
    logic signed [COEF_W-1:0] b1;
    logic signed [COEF_W-1:0] b2;
    logic signed [COEF_W-1:0] a1;
    logic signed [COEF_W-1:0] a2;
  } iir_coef_t;

  // Sample value tagged with its channel number
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] data;
    logic [CH_W-1:0]            ch;
  } iir_sample_t;

endpackage

// ==== iir_cfg_pkg.sv ====
/*
 * IIR configuration definitions
 * APB bus widths and the register map of the biquad bank
 */

package iir_cfg_pkg;

  // ------------------------------------------------------------
  // APB3 bus widths
  // ------------------------------------------------------------

  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;

  // ------------------------------------------------------------
  // Register offsets from the slave base address
  // ------------------------------------------------------------

  typedef enum logic [APB_ADDR_W-1:0] {
    // Feedforward taps, low 16 bits used
    REG_B0     = 12'h000,
    REG_B1     = 12'h004,
    REG_B2     = 12'h008,
    // Feedback taps, subtracted in the sum
    REG_A1     = 12'h00C,
    REG_A2     = 12'h010,
    // One bit per channel, set means pass through
    REG_BYPASS = 12'h014,
    // Sticky saturation flags
    // Writing ones clears the matching flags
    REG_SAT    = 12'h018
  } iir_reg_e;

endpackage

// ==== iir_biquad_apb_slave.sv ====
/*
 * Biquad bank APB3 slave
 * Holds the shared coefficients, the bypass mask and reads back the
 * sticky saturation flags, which a write clears bit by bit
 */

`timescale 1ns/1ps

module iir_biquad_apb_slave #(
  parameter int NUM_CH = 4,
  parameter logic [iir_cfg_pkg::APB_ADDR_W-1:0] APB_BASE_ADDR = 12'h100
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [iir_cfg_pkg::APB_ADDR_W-1:0]  paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [iir_cfg_pkg::APB_DATA_W-1:0]  pwdata,
  output logic                                pready,
  output logic [iir_cfg_pkg::APB_DATA_W-1:0]  prdata,
  input  logic [NUM_CH-1:0]                   sat_flags,
  output iir_dsp_pkg::iir_coef_t              coef,
  output logic [NUM_CH-1:0]                   bypass,
  output logic [NUM_CH-1:0]                   sat_clear
);

  localparam int COEF_W = iir_dsp_pkg::COEF_W;

  // Access completes when the setup and enable phases meet pready
  logic                                access;
  logic [iir_cfg_pkg::APB_ADDR_W-1:0]  offset;
  logic [iir_cfg_pkg::APB_DATA_W-1:0]  rd_data;

  assign access = psel && penable && pready;

  // Offset relative to the block base
  assign offset = paddr - APB_BASE_ADDR;

  // ------------------------------------------------------------
  // Readback mux
  // ------------------------------------------------------------

  always_comb begin
    rd_data = '0;
    case (offset)
      // Coefficients read back zero extended
      iir_cfg_pkg::REG_B0:     rd_data[COEF_W-1:0] = coef.b0;
      iir_cfg_pkg::REG_B1:     rd_data[COEF_W-1:0] = coef.b1;
      iir_cfg_pkg::REG_B2:     rd_data[COEF_W-1:0] = coef.b2;
      iir_cfg_pkg::REG_A1:     rd_data[COEF_W-1:0] = coef.a1;
      iir_cfg_pkg::REG_A2:     rd_data[COEF_W-1:0] = coef.a2;
      iir_cfg_pkg::REG_BYPASS: rd_data[NUM_CH-1:0] = bypass;
      iir_cfg_pkg::REG_SAT:    rd_data[NUM_CH-1:0] = sat_flags;
      default:                 rd_data = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Bus response and register writes
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pready    <= 1'b0;
      prdata    <= '0;
      coef      <= '0;
      bypass    <= '0;
      sat_clear <= '0;
    end else begin
      // One cycle of latency on pready after psel
      pready    <= psel;
      prdata    <= '0;
      // Clear mask lasts a single cycle
      sat_clear <= '0;

      // Read data shows up in the cycle after completion
      if (access && !pwrite) begin
        prdata <= rd_data;
      end

      if (access && pwrite) begin
        case (offset)
          iir_cfg_pkg::REG_B0:     coef.b0   <= pwdata[COEF_W-1:0];
          iir_cfg_pkg::REG_B1:     coef.b1   <= pwdata[COEF_W-1:0];
          iir_cfg_pkg::REG_B2:     coef.b2   <= pwdata[COEF_W-1:0];
          iir_cfg_pkg::REG_A1:     coef.a1   <= pwdata[COEF_W-1:0];
          iir_cfg_pkg::REG_A2:     coef.a2   <= pwdata[COEF_W-1:0];
          iir_cfg_pkg::REG_BYPASS: bypass    <= pwdata[NUM_CH-1:0];
          // Written ones become the clear mask
          iir_cfg_pkg::REG_SAT:    sat_clear <= pwdata[NUM_CH-1:0];
          default:                 ;
        endcase
      end
    end
  end

endmodule

// ==== iir_sample_fanout.sv ====
/*
 * Sample fanout
 * Registers each input sample and raises the strobe of its channel
 */

`timescale 1ns/1ps

module iir_sample_fanout #(
  parameter int NUM_CH = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   in_valid,
  input  iir_dsp_pkg::iir_sample_t               in_sample,
  output logic [NUM_CH-1:0]                      ch_valid,
  output logic signed [iir_dsp_pkg::SAMPLE_W-1:0] ch_data
);

  // One-hot channel select for the incoming sample
  logic [NUM_CH-1:0] ch_sel;

  // Channel numbers of NUM_CH or above match no bit and are dropped
  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      ch_sel[i] = in_valid && (in_sample.ch == i);
    end
  end

  // Strobe register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ch_valid <= '0;
    end else begin
      ch_valid <= ch_sel;
    end
  end

  // Shared data bus, the strobe tells each channel when to take it
  always_ff @(posedge clk) begin
    if (in_valid) begin
      ch_data <= in_sample.data;
    end
  end

endmodule

// ==== iir_biquad_channel.sv ====
/*
 * Biquad channel
 * Direct form I section with truncating rescale, output clamp
 * and per-channel bypass
 */

`timescale 1ns/1ps

module iir_biquad_channel #(
  parameter int NUM_CH = 4,
  parameter int CH_IDX = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 x_valid,
  input  logic signed [iir_dsp_pkg::SAMPLE_W-1:0] x_data,
  input  iir_dsp_pkg::iir_coef_t                  coef,
  input  logic [NUM_CH-1:0]                       bypass,
  output logic                                    y_valid,
  output logic signed [iir_dsp_pkg::SAMPLE_W-1:0] y_data,
  output logic                                    sat_pulse
);

  localparam int SW = iir_dsp_pkg::SAMPLE_W;
  localparam int ACC_W = iir_dsp_pkg::ACC_W;

  // Clamp bounds of the output sample in accumulator width
  localparam logic signed [ACC_W-1:0] Y_MAX = ACC_W'((2 ** (SW - 1)) - 1);
  localparam logic signed [ACC_W-1:0] Y_MIN = -Y_MAX - 1;

  // Delay line
  logic signed [SW-1:0]   x1, x2, y1, y2;
  // Tap products, exact in twice the sample width
  logic signed [2*SW-1:0] p_b0, p_b1, p_b2, p_a1, p_a2;
  logic signed [ACC_W-1:0] acc, acc_shift;
  logic signed [SW-1:0]   y_clamp, y_next;
  logic                   clamp, bypass_ch;

  assign bypass_ch = bypass[CH_IDX];

  // ------------------------------------------------------------
  // Multiply accumulate and rescale
  // ------------------------------------------------------------

  always_comb begin
    p_b0 = $signed(coef.b0) * x_data;
    p_b1 = $signed(coef.b1) * x1;
    p_b2 = $signed(coef.b2) * x2;
    p_a1 = $signed(coef.a1) * y1;
    p_a2 = $signed(coef.a2) * y2;
    acc  = p_b0 + p_b1 + p_b2 - p_a1 - p_a2;
    // Back to sample scale, rounds toward minus infinity
    acc_shift = acc >>> iir_dsp_pkg::COEF_FRAC;

    clamp = 1'b1;
    if (acc_shift > Y_MAX) begin
      y_clamp = Y_MAX[SW-1:0];
    end else if (acc_shift < Y_MIN) begin
      y_clamp = Y_MIN[SW-1:0];
    end else begin
      y_clamp = acc_shift[SW-1:0];
      clamp   = 1'b0;
    end

    // Bypass passes the input untouched
    y_next = bypass_ch ? x_data : y_clamp;
  end

  // ------------------------------------------------------------
  // Filter state
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x1        <= '0;
      x2        <= '0;
      y1        <= '0;
      y2        <= '0;
      y_valid   <= 1'b0;
      sat_pulse <= 1'b0;
    end else begin
      y_valid   <= x_valid;
      sat_pulse <= x_valid && clamp && !bypass_ch;
      // History follows the selected output in both modes
      if (x_valid) begin
        x1 <= x_data;
        x2 <= x1;
        y1 <= y_next;
        y2 <= y1;
      end
    end
  end

  // Output sample register
  always_ff @(posedge clk) begin
    if (x_valid) begin
      y_data <= y_next;
    end
  end

endmodule

// ==== iir_output_collector.sv ====
/*
 * Output collector
 * Merges the channel outputs into one tagged stream and keeps
 * the sticky saturation flags
 */

`timescale 1ns/1ps

module iir_output_collector #(
  parameter int NUM_CH = 4
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic [NUM_CH-1:0]                          y_valid,
  input  logic [NUM_CH-1:0][iir_dsp_pkg::SAMPLE_W-1:0] y_data,
  input  logic [NUM_CH-1:0]                          sat_pulse,
  input  logic [NUM_CH-1:0]                          sat_clear,
  output logic                                       out_valid,
  output iir_dsp_pkg::iir_sample_t                   out_sample,
  output logic [NUM_CH-1:0]                          sat_flags
);

  localparam int CH_W = iir_dsp_pkg::CH_W;

  logic                             any_valid;
  logic [CH_W-1:0]                  sel_ch;
  logic [iir_dsp_pkg::SAMPLE_W-1:0] sel_data;

  // At most one channel is valid per cycle
  always_comb begin
    any_valid = |y_valid;
    sel_ch    = '0;
    sel_data  = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      if (y_valid[i]) begin
        sel_ch   = CH_W'(i);
        sel_data = y_data[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      sat_flags <= '0;
    end else begin
      out_valid <= any_valid;
      // New saturation wins over a clear in the same cycle
      sat_flags <= (sat_flags & ~sat_clear) | sat_pulse;
    end
  end

  // Tagged output payload
  always_ff @(posedge clk) begin
    if (any_valid) begin
      out_sample.data <= sel_data;
      out_sample.ch   <= sel_ch;
    end
  end

endmodule

// ==== iir_biquad_bank.sv ====
/*
 * Biquad filter bank top level
 * APB configured coefficients shared by NUM_CH filter channels
 */

`timescale 1ns/1ps

module iir_biquad_bank #(
  parameter int NUM_CH = 4,
  parameter logic [iir_cfg_pkg::APB_ADDR_W-1:0] APB_BASE_ADDR = 12'h100
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [iir_cfg_pkg::APB_ADDR_W-1:0] paddr,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [iir_cfg_pkg::APB_DATA_W-1:0] pwdata,
  output logic                               pready,
  output logic [iir_cfg_pkg::APB_DATA_W-1:0] prdata,
  input  logic                               in_valid,
  input  iir_dsp_pkg::iir_sample_t           in_sample,
  output logic                               out_valid,
  output iir_dsp_pkg::iir_sample_t           out_sample
);

  localparam int SW = iir_dsp_pkg::SAMPLE_W;

  iir_dsp_pkg::iir_coef_t       coef;
  logic [NUM_CH-1:0]            bypass, sat_clear, sat_flags;
  logic [NUM_CH-1:0]            ch_valid, y_valid, sat_pulse;
  logic signed [SW-1:0]         ch_data;
  logic [NUM_CH-1:0][SW-1:0]    y_data;

  // ------------------------------------------------------------
  // Configuration slave
  // ------------------------------------------------------------

  iir_biquad_apb_slave #(
    .NUM_CH        (NUM_CH),
    .APB_BASE_ADDR (APB_BASE_ADDR)
  ) u_apb_slave (
    .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
    .pready, .prdata, .sat_flags, .coef, .bypass, .sat_clear
  );

  // ------------------------------------------------------------
  // Sample path, three register stages
  // ------------------------------------------------------------

  iir_sample_fanout #(.NUM_CH(NUM_CH)) u_fanout (
    .clk, .rst_n, .in_valid, .in_sample, .ch_valid, .ch_data
  );

  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    iir_biquad_channel #(.NUM_CH(NUM_CH), .CH_IDX(i)) u_channel (
      .clk, .rst_n,
      .x_valid   (ch_valid[i]),
      .x_data    (ch_data),
      .coef      (coef),
      .bypass    (bypass),
      .y_valid   (y_valid[i]),
      .y_data    (y_data[i]),
      .sat_pulse (sat_pulse[i])
    );
  end

  iir_output_collector #(.NUM_CH(NUM_CH)) u_collector (
    .clk, .rst_n, .y_valid, .y_data, .sat_pulse, .sat_clear,
    .out_valid, .out_sample, .sat_flags
  );

endmodule

// ==== iir_biquad_checker.sv ====
/*
 * Biquad bank checker
 * Concurrent checks on sample latency, channel tags and APB pready
 */

`timescale 1ns/1ps

module iir_biquad_checker #(
  parameter int NUM_CH = 4
) (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     psel,
  input logic                     pready,
  input logic                     in_valid,
  input iir_dsp_pkg::iir_sample_t in_sample,
  input logic                     out_valid,
  input iir_dsp_pkg::iir_sample_t out_sample
);

  // Fanout, channel and collector stages
  localparam int LATENCY = 3;

  // Failed assertions so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // Sample that a channel will accept
  logic in_ok;

  assign in_ok = in_valid && (int'(in_sample.ch) < NUM_CH);

  // ------------------------------------------------------------
  // Sample path
  // ------------------------------------------------------------

  // Every accepted sample leaves exactly three cycles later
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    in_ok |-> ##LATENCY out_valid)
    else begin
      $error("out_valid missing three cycles after an accepted sample");
      fail_count++;
    end

  // No output without an accepted sample three cycles earlier
  a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(in_ok, LATENCY))
    else begin
      $error("out_valid without an accepted sample three cycles earlier");
      fail_count++;
    end

  // Output tag carries the channel of its input
  a_tag: assert property (@(posedge clk) disable iff (!rst_n)
    in_ok |-> ##LATENCY (out_sample.ch == $past(in_sample.ch, LATENCY)))
    else begin
      $error("out_sample.ch differs from the channel of its input");
      fail_count++;
    end

  // ------------------------------------------------------------
  // APB
  // ------------------------------------------------------------

  a_pready: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(psel) |-> !pready)
    else begin
      $error("pready high after a cycle with psel low");
      fail_count++;
    end

endmodule

// ==== tb_iir_biquad_bank.sv ====
/*
 * Biquad bank testbench
 * Directed tests over APB and the sample path, checked against
 * a behavioral direct form I model per channel
 */

`timescale 1ns/1ps

module tb_iir_biquad_bank;

  localparam int NUM_CH = 4;
  localparam logic [11:0] APB_BASE_ADDR = 12'h100;
  localparam logic [31:0] SEED = 32'h92a5;
  localparam int LATENCY = 3;
  // Roughly four hundred cycles of tests, limit leaves a wide margin
  localparam int MAX_CYCLES = 4000;
  localparam int APB_WAIT_MAX = 16;
  localparam int DRAIN_MAX = 64;
  localparam logic [31:0] ALL_CH = (32'h1 << NUM_CH) - 1;
  localparam longint Q_ONE = 64'sd1 << iir_dsp_pkg::COEF_FRAC;

  // Expected output with the cycle it is due in
  typedef struct packed {
    logic [15:0] data;
    logic [7:0]  ch;
    logic [31:0] cycle;
  } exp_entry_t;

  logic clk, rst_n;
  logic [11:0] paddr;
  logic psel, penable, pwrite, pready;
  logic [31:0] pwdata, prdata;
  logic in_valid, out_valid;
  iir_dsp_pkg::iir_sample_t in_sample, out_sample;

  int cycle_cnt = 0;
  exp_entry_t exp_q[$];

  // Register mirror and per channel model state
  iir_dsp_pkg::iir_coef_t coef_m;
  logic [NUM_CH-1:0] bypass_m, exp_sat;
  int x1_m [NUM_CH];
  int x2_m [NUM_CH];
  int y1_m [NUM_CH];
  int y2_m [NUM_CH];

  iir_biquad_bank #(
    .NUM_CH        (NUM_CH),
    .APB_BASE_ADDR (APB_BASE_ADDR)
  ) UUT (
    .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .pready,
    .prdata, .in_valid, .in_sample, .out_valid, .out_sample
  );

  bind iir_biquad_bank iir_biquad_checker #(.NUM_CH(NUM_CH)) u_checker (
    .clk(clk), .rst_n(rst_n), .psel(psel), .pready(pready),
    .in_valid(in_valid), .in_sample(in_sample),
    .out_valid(out_valid), .out_sample(out_sample)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Error handling and timeout
  // ------------------------------------------------------------

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic error_stop(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic value_mismatch(input string name, input longint got, input longint exp);
    $display("error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    abort_run();
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      error_stop("timeout, the run exceeded its cycle limit");
    end
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  // Rescale that rounds toward minus infinity
  function automatic longint floor_rescale(input longint acc);
    if (acc >= 0) begin
      return acc / Q_ONE;
    end
    return -((-acc + Q_ONE - 1) / Q_ONE);
  endfunction

  task automatic model_channel(input int ch, input int x, output int y);
    longint acc, q;
    if (bypass_m[ch]) begin
      y = x;
    end else begin
      acc = longint'($signed(coef_m.b0)) * x + longint'($signed(coef_m.b1)) * x1_m[ch]
          + longint'($signed(coef_m.b2)) * x2_m[ch]
          - longint'($signed(coef_m.a1)) * y1_m[ch]
          - longint'($signed(coef_m.a2)) * y2_m[ch];
      q = floor_rescale(acc);
      if (q > 32767) begin
        y = 32767;
        exp_sat[ch] = 1'b1;
      end else if (q < -32768) begin
        y = -32768;
        exp_sat[ch] = 1'b1;
      end else begin
        y = int'(q);
      end
    end
    // History follows the chosen output
    x2_m[ch] = x1_m[ch];
    x1_m[ch] = x;
    y2_m[ch] = y1_m[ch];
    y1_m[ch] = y;
  endtask

  // ------------------------------------------------------------
  // APB driver
  // ------------------------------------------------------------

  task automatic bus_transfer(input logic [11:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    int waits;
    waits = 0;
    @(posedge clk);
    #1;
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready && waits < APB_WAIT_MAX) begin
      @(negedge clk);
      waits++;
    end
    assert (pready) else error_stop("APB access never saw pready");
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    // Read data sits one cycle after completion
    @(negedge clk);
    rdata = prdata;
  endtask

  task automatic apb_write(input iir_cfg_pkg::iir_reg_e off, input logic [31:0] data);
    logic [31:0] unused;
    bus_transfer(APB_BASE_ADDR + 12'(off), 1'b1, data, unused);
    case (off)
      iir_cfg_pkg::REG_B0:     coef_m.b0 = data[15:0];
      iir_cfg_pkg::REG_B1:     coef_m.b1 = data[15:0];
      iir_cfg_pkg::REG_B2:     coef_m.b2 = data[15:0];
      iir_cfg_pkg::REG_A1:     coef_m.a1 = data[15:0];
      iir_cfg_pkg::REG_A2:     coef_m.a2 = data[15:0];
      iir_cfg_pkg::REG_BYPASS: bypass_m  = data[NUM_CH-1:0];
      iir_cfg_pkg::REG_SAT:    exp_sat   = exp_sat & ~data[NUM_CH-1:0];
      default:                 ;
    endcase
  endtask

  task automatic apb_read(input iir_cfg_pkg::iir_reg_e off, input logic [31:0] exp);
    logic [31:0] rdata;
    bus_transfer(APB_BASE_ADDR + 12'(off), 1'b0, 32'h0, rdata);
    assert (pready) else error_stop("no pready alongside the read data");
    assert (rdata == exp) else value_mismatch("prdata", rdata, exp);
  endtask

  task automatic load_coefs(input logic [15:0] b0, input logic [15:0] b1,
                            input logic [15:0] b2, input logic [15:0] a1,
                            input logic [15:0] a2);
    apb_write(iir_cfg_pkg::REG_B0, 32'(b0));
    apb_write(iir_cfg_pkg::REG_B1, 32'(b1));
    apb_write(iir_cfg_pkg::REG_B2, 32'(b2));
    apb_write(iir_cfg_pkg::REG_A1, 32'(a1));
    apb_write(iir_cfg_pkg::REG_A2, 32'(a2));
  endtask

  // ------------------------------------------------------------
  // Sample driver and output monitor
  // ------------------------------------------------------------

  // Leaves in_valid high so that bursts run back to back
  task automatic send_sample(input int ch, input int x);
    exp_entry_t e;
    int y;
    @(posedge clk);
    #1;
    in_valid       = 1'b1;
    in_sample.ch   = 8'(ch);
    in_sample.data = 16'(x);
    if (ch < NUM_CH) begin
      model_channel(ch, x, y);
      e.data  = 16'(y);
      e.ch    = 8'(ch);
      e.cycle = 32'(cycle_cnt + LATENCY);
      exp_q.push_back(e);
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic drain_pipeline();
    int waits;
    waits = 0;
    idle_cycle();
    while (exp_q.size() != 0 && waits < DRAIN_MAX) begin
      @(posedge clk);
      waits++;
    end
    assert (exp_q.size() == 0) else error_stop("expected output samples never arrived");
  endtask

  always @(negedge clk) begin : monitor
    exp_entry_t e;
    if (rst_n && out_valid) begin
      assert (exp_q.size() != 0) else error_stop("output sample with none pending");
      e = exp_q.pop_front();
      assert (cycle_cnt == int'(e.cycle))
        else value_mismatch("out_valid cycle", cycle_cnt, e.cycle);
      assert (out_sample.ch == e.ch) else value_mismatch("out_sample.ch", out_sample.ch, e.ch);
      assert (out_sample.data == e.data)
        else value_mismatch("out_sample.data", longint'($signed(out_sample.data)),
                            longint'($signed(e.data)));
    end
  end

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  task automatic register_readback();
    iir_cfg_pkg::iir_reg_e regs [7];
    logic [31:0] wdata;
    regs = '{iir_cfg_pkg::REG_B0, iir_cfg_pkg::REG_B1, iir_cfg_pkg::REG_B2,
             iir_cfg_pkg::REG_A1, iir_cfg_pkg::REG_A2, iir_cfg_pkg::REG_BYPASS,
             iir_cfg_pkg::REG_SAT};
    foreach (regs[i]) begin
      apb_read(regs[i], 32'h0);
    end
    // Upper bits of every register read back as zero
    for (int i = 0; i < 6; i++) begin
      wdata = $urandom;
      apb_write(regs[i], wdata);
      if (i < 5) begin
        apb_read(regs[i], {16'h0, wdata[15:0]});
      end else begin
        apb_read(regs[i], 32'(wdata[NUM_CH-1:0]));
      end
    end
    for (int i = 0; i < 6; i++) begin
      apb_write(regs[i], 32'h0);
    end
  endtask

  // Zero every delay line through bypass
  task automatic flush_history();
    logic [31:0] saved;
    saved = 32'(bypass_m);
    apb_write(iir_cfg_pkg::REG_BYPASS, ALL_CH);
    repeat (2) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        send_sample(ch, 0);
      end
    end
    drain_pipeline();
    apb_write(iir_cfg_pkg::REG_BYPASS, saved);
  endtask

  task automatic bypass_passthrough();
    apb_write(iir_cfg_pkg::REG_BYPASS, ALL_CH);
    repeat (32) begin
      send_sample($urandom_range(NUM_CH - 1), int'($urandom_range(65535)) - 32768);
      if ($urandom_range(3) == 0) begin
        idle_cycle();
      end
    end
    drain_pipeline();
    apb_write(iir_cfg_pkg::REG_BYPASS, 32'h0);
  endtask

  task automatic impulse_response();
    // Stable section, poles inside the unit circle
    load_coefs(16'h4000, 16'h2000, 16'h1000, 16'hD000, 16'h1800);
    flush_history();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      send_sample(ch, 8192);
      repeat (11) send_sample(ch, 0);
    end
    drain_pipeline();
  endtask

  task automatic interleaved_channels();
    repeat (64) begin
      send_sample($urandom_range(NUM_CH - 1), int'($urandom_range(16383)) - 8192);
    end
    drain_pipeline();
  endtask

  task automatic saturation_flags();
    apb_write(iir_cfg_pkg::REG_SAT, ALL_CH);
    apb_read(iir_cfg_pkg::REG_SAT, 32'h0);
    // Gain near two, channel 1 bypassed
    load_coefs(16'h7FFF, 16'h0, 16'h0, 16'h0, 16'h0);
    apb_write(iir_cfg_pkg::REG_BYPASS, 32'h2);
    send_sample(0, 30000);
    send_sample(1, 30000);
    send_sample(2, -30000);
    send_sample(3, 100);
    drain_pipeline();
    assert (exp_sat == 4'b0101) else value_mismatch("model saturation mask", exp_sat, 4'b0101);
    apb_read(iir_cfg_pkg::REG_SAT, 32'(exp_sat));
    apb_write(iir_cfg_pkg::REG_SAT, 32'h1);
    apb_read(iir_cfg_pkg::REG_SAT, 32'(exp_sat));
  endtask

  task automatic dropped_channel();
    apb_write(iir_cfg_pkg::REG_BYPASS, 32'h0);
    send_sample(NUM_CH, 1234);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      send_sample(ch, 1000 * (ch + 1));
    end
    send_sample(255, -5);
    send_sample(0, 77);
    drain_pipeline();
    // A stray output would reach the monitor here
    repeat (8) idle_cycle();
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    void'($urandom(SEED));
    rst_n     = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    in_valid  = 1'b0;
    in_sample = '0;
    coef_m    = '0;
    bypass_m  = '0;
    exp_sat   = '0;
    foreach (x1_m[i]) begin
      x1_m[i] = 0;
      x2_m[i] = 0;
      y1_m[i] = 0;
      y2_m[i] = 0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    register_readback();
    bypass_passthrough();
    impulse_response();
    interleaved_channels();
    saturation_flags();
    dropped_channel();

    repeat (4) @(posedge clk);
    if (UUT.u_checker.fail_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      error_stop("concurrent checks in the bound checker failed");
    end
  end

endmodule

// ==== files.f ====
iir_dsp_pkg.sv
iir_cfg_pkg.sv
iir_biquad_apb_slave.sv
iir_sample_fanout.sv
iir_biquad_channel.sv
iir_output_collector.sv
iir_biquad_bank.sv
iir_biquad_checker.sv
tb_iir_biquad_bank.sv

// ==== Makefile ====
# Verilator build and run for the biquad filter bank testbench

VERILATOR ?= verilator
TOP       ?= tb_iir_biquad_bank
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
